// ==== Bender.yml ====
package:
  name: flash_boot

sources:
  - flash_boot_pkg.sv
  - spi_flash_reader.sv
  - boot_fifo.sv
  - wb_boot_writer.sv
  - flash_boot_top.sv
  - target: test
    files:
      - spi_flash_model.sv
      - tb_flash_boot.sv

// ==== boot_fifo.sv ====
`default_nettype none

module boot_fifo import flash_boot_pkg::*; #(
   parameter int fifo_depth = 8
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              push,
   input  logic [word_w-1:0] push_data,
   input  logic              pop,
   output logic              full,
   output logic              empty,
   output logic [word_w-1:0] pop_data
);

   localparam int aw = $clog2(fifo_depth);

   logic [word_w-1:0] mem [fifo_depth];
   logic [aw:0]       wr_ptr;                  // Extra MSB marks the lap
   logic [aw:0]       rd_ptr;

   assign empty = (wr_ptr == rd_ptr);
   assign full = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);

   // Head word shown without a pop
   assign pop_data = mem[rd_ptr[aw-1:0]];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr[aw-1:0]] <= push_data;
      end
   end

   a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
      push |-> !full);

   a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
      pop |-> !empty);

endmodule

`default_nettype wire

// ==== files.f ====
flash_boot_pkg.sv
spi_flash_reader.sv
boot_fifo.sv
wb_boot_writer.sv
flash_boot_top.sv
spi_flash_model.sv
tb_flash_boot.sv

// ==== flash_boot_pkg.sv ====
`default_nettype none

package flash_boot_pkg;

   // Data path
   localparam int word_w = 32;                 // System word
   localparam int bytes_per_word = word_w / 8;

   // Flash side
   localparam int flash_addr_w = 24;           // 3-byte addressing

   // Bus side
   localparam int wb_addr_w = 32;              // Byte address

   // Length of one boot transfer in words
   localparam int count_w = 16;

   // Standard single-wire read, no dummy cycles
   localparam logic [7:0] cmd_read = 8'h03;

endpackage

`default_nettype wire

// ==== flash_boot_top.sv ====
`default_nettype none

module flash_boot_top import flash_boot_pkg::*; #(
   parameter int sck_div = 2,
   parameter int fifo_depth = 8
) (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      start,
   input  logic [flash_addr_w-1:0]   flash_addr,
   input  logic [count_w-1:0]        word_count,
   input  logic [wb_addr_w-1:0]      mem_base,
   output logic                      busy,
   output logic                      done,
   output logic                      spi_sck,
   output logic                      spi_cs_n,
   output logic                      spi_mosi,
   input  logic                      spi_miso,
   output logic                      wb_cyc,
   output logic                      wb_stb,
   output logic                      wb_we,
   output logic [wb_addr_w-1:0]      wb_adr,
   output logic [word_w-1:0]         wb_dat_w,
   output logic [bytes_per_word-1:0] wb_sel,
   input  logic                      wb_ack
);

   logic              start_req;
   logic              push;
   logic [word_w-1:0] push_data;
   logic              full;
   logic              empty;
   logic              pop;
   logic [word_w-1:0] pop_data;

   // Reader can go idle before the writer drains, so qualify here
   assign start_req = start && !busy;

   spi_flash_reader #(
      .sck_div    (sck_div)
   ) i_spi_flash_reader (
      .clk        (clk),
      .arst_n     (arst_n),
      .start      (start_req),
      .flash_addr (flash_addr),
      .word_count (word_count),
      .spi_miso   (spi_miso),
      .full       (full),
      .spi_sck    (spi_sck),
      .spi_cs_n   (spi_cs_n),
      .spi_mosi   (spi_mosi),
      .push       (push),
      .push_data  (push_data)
   );

   boot_fifo #(
      .fifo_depth (fifo_depth)
   ) i_boot_fifo (
      .clk        (clk),
      .arst_n     (arst_n),
      .push       (push),
      .push_data  (push_data),
      .pop        (pop),
      .full       (full),
      .empty      (empty),
      .pop_data   (pop_data)
   );

   wb_boot_writer i_wb_boot_writer (
      .clk        (clk),
      .arst_n     (arst_n),
      .start      (start_req),
      .mem_base   (mem_base),
      .word_count (word_count),
      .empty      (empty),
      .pop_data   (pop_data),
      .wb_ack     (wb_ack),
      .pop        (pop),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_sel     (wb_sel),
      .busy       (busy),
      .done       (done)
   );

endmodule

`default_nettype wire

// ==== spi_flash_model.sv ====
`default_nettype none

module spi_flash_model import flash_boot_pkg::*; (
   input  logic spi_sck,
   input  logic spi_cs_n,
   input  logic spi_mosi,
   output logic spi_miso,
   output logic bad_cmd
);

   timeunit 1ns;
   timeprecision 100ps;

   logic [31:0]             header = '0;       // Opcode and address as received
   logic [flash_addr_w-1:0] rd_addr;
   logic [7:0]              rd_byte;
   int                      bit_cnt = 0;       // Rising edges since select
   int                      data_idx;

   // Fixed content rule for the whole array
   function automatic logic [7:0] byte_at(input logic [flash_addr_w-1:0] a);
      return (a[23:16] ^ a[15:8] ^ a[7:0]) + 8'h5a;
   endfunction

   initial begin
      spi_miso = 1'b0;
      bad_cmd = 1'b0;
   end

   // Command and address come in on the rising edge
   always @(posedge spi_sck or posedge spi_cs_n) begin
      if (spi_cs_n) begin
         bit_cnt <= 0;
      end else begin
         if (bit_cnt < 32)
            header <= {header[30:0], spi_mosi};
         bit_cnt <= bit_cnt + 1;
      end
   end

   // Data goes out on the falling edge, address steps after every byte
   always @(negedge spi_sck) begin
      if (!spi_cs_n && bit_cnt >= 32) begin
         if (bit_cnt == 32 && header[31:24] != cmd_read)
            bad_cmd <= 1'b1;
         data_idx = bit_cnt - 32;
         rd_addr = header[23:0] + flash_addr_w'(data_idx / 8);
         rd_byte = byte_at(rd_addr);
         spi_miso <= rd_byte[7 - (data_idx % 8)];   // MSB first
      end
   end

endmodule

`default_nettype wire

// ==== spi_flash_reader.sv ====
`default_nettype none

module spi_flash_reader import flash_boot_pkg::*; #(
   parameter int sck_div = 2
) (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    start,
   input  logic [flash_addr_w-1:0] flash_addr,
   input  logic [count_w-1:0]      word_count,
   input  logic                    spi_miso,
   input  logic                    full,
   output logic                    spi_sck,
   output logic                    spi_cs_n,
   output logic                    spi_mosi,
   output logic                    push,
   output logic [word_w-1:0]       push_data
);

   localparam int div_w = (sck_div > 1) ? $clog2(sck_div) : 1;
   localparam int tx_w = 8 + flash_addr_w;     // Opcode plus address

   localparam logic [2:0] st_idle   = 3'd0;
   localparam logic [2:0] st_cmd    = 3'd1;
   localparam logic [2:0] st_addr   = 3'd2;
   localparam logic [2:0] st_data   = 3'd3;
   localparam logic [2:0] st_hold   = 3'd4;   // Word ready, waiting on FIFO
   localparam logic [2:0] st_finish = 3'd5;

   logic [2:0]         state;
   logic [div_w-1:0]   div_cnt;
   logic [4:0]         bit_cnt;                // Wraps once per 32 bits
   logic [tx_w-1:0]    tx_sr;
   logic [7:0]         rx_byte;
   logic [word_w-1:0]  word_sr;
   logic [count_w-1:0] words_left;
   logic               shifting;
   logic               tick;
   logic               rise;
   logic               fall;

   assign shifting = (state == st_cmd) || (state == st_addr) || (state == st_data);
   assign tick = shifting && (div_cnt == div_w'(sck_div - 1));
   assign rise = tick && !spi_sck;
   assign fall = tick && spi_sck;

   assign spi_mosi = tx_sr[tx_w-1];            // MSB first
   assign push = (state == st_hold) && !full;
   assign push_data = word_sr;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= st_idle;
         div_cnt <= '0;
         bit_cnt <= '0;
         tx_sr <= '0;
         words_left <= '0;
         spi_sck <= 1'b0;
         spi_cs_n <= 1'b1;
      end else begin
         div_cnt <= (shifting && !tick) ? div_cnt + 1'b1 : '0;
         if (tick) begin
            spi_sck <= !spi_sck;
         end
         case (state)
            st_idle: begin
               if (start && (word_count != '0)) begin
                  state <= st_cmd;
                  spi_cs_n <= 1'b0;
                  tx_sr <= {cmd_read, flash_addr};
                  words_left <= word_count;
                  bit_cnt <= '0;
               end
            end
            st_cmd, st_addr, st_data: begin
               if (fall) begin                     // End of one bit
                  bit_cnt <= bit_cnt + 1'b1;
                  tx_sr <= {tx_sr[tx_w-2:0], 1'b0};
                  if (state == st_cmd && bit_cnt == 5'd7) begin
                     state <= st_addr;
                  end else if (state == st_addr && bit_cnt == 5'd31) begin
                     state <= st_data;
                  end else if (state == st_data && bit_cnt == 5'd31) begin
                     state <= st_hold;             // SCK is low from here
                  end
               end
            end
            st_hold: begin
               if (!full) begin
                  words_left <= words_left - 1'b1;
                  if (words_left == count_w'(1)) begin
                     state <= st_finish;
                     spi_cs_n <= 1'b1;
                  end else begin
                     state <= st_data;
                  end
               end
            end
            st_finish: state <= st_idle;           // One cycle of deselect
            default: state <= st_idle;
         endcase
      end
   end

   // Receive path, bytes land little-endian in the word
   always_ff @(posedge clk) begin
      if (rise && state == st_data) begin
         rx_byte <= {rx_byte[6:0], spi_miso};
      end
      if (fall && state == st_data && bit_cnt[2:0] == 3'd7) begin
         word_sr <= {rx_byte, word_sr[word_w-1:8]};
      end
   end

   a_cs_idle: assert property (@(posedge clk) disable iff (!arst_n)
      (state == st_idle) |-> spi_cs_n);

   a_push_full: assert property (@(posedge clk) disable iff (!arst_n)
      push |-> !full);

endmodule

`default_nettype wire

// ==== tb_flash_boot.sv ====
`default_nettype none

module tb_flash_boot import flash_boot_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int sck_div = 2;
   localparam int fifo_depth = 8;
   localparam int total_words = 16 + 5 + 40 + 1 + 12;
   localparam int stall_cycles = 12 * 32 * 2 * sck_div;   // About 12 SPI words
   localparam int watchdog_cycles = total_words * 4 * 40 * sck_div + stall_cycles + 2000;

   logic clk = 1'b0;
   logic arst_n, start, busy, done, bad_cmd;
   logic [flash_addr_w-1:0] flash_addr;
   logic [count_w-1:0] word_count;
   logic [wb_addr_w-1:0] mem_base, wb_adr, cur_base;
   logic spi_sck, spi_cs_n, spi_mosi, spi_miso;
   logic wb_cyc, wb_stb, wb_we;
   logic wb_ack = 1'b0;
   logic [word_w-1:0] wb_dat_w;
   logic [bytes_per_word-1:0] wb_sel;
   logic [flash_addr_w-1:0] cur_flash;
   logic [count_w-1:0] cur_count;
   logic [31:0] lfsr_state = 32'h416d6520;
   logic max_wait = 1'b0;
   logic pending = 1'b0;
   logic saw_full = 1'b0;
   int stall = 0;
   int wait_left, write_idx;
   int total_writes = 0;
   int total_done = 0;
   int first_write = 0;
   int done_start = 0;
   int error_count = 0;
   int err_start = 0;
   int test_count = 0;
   int pass_count = 0;

   always #2 clk = ~clk;

   flash_boot_top #(.sck_div(sck_div), .fifo_depth(fifo_depth)) i_flash_boot_top (.*);

   spi_flash_model i_spi_flash_model (
      .spi_sck  (spi_sck),
      .spi_cs_n (spi_cs_n),
      .spi_mosi (spi_mosi),
      .spi_miso (spi_miso),
      .bad_cmd  (bad_cmd)
   );

   function automatic logic [7:0] flash_byte(input logic [flash_addr_w-1:0] a);
      return (a[23:16] ^ a[15:8] ^ a[7:0]) + 8'h5a;
   endfunction

   // Lowest address lands in bits 7:0
   function automatic logic [word_w-1:0] ref_word(input logic [flash_addr_w-1:0] a);
      return {flash_byte(a + 24'd3), flash_byte(a + 24'd2), flash_byte(a + 24'd1),
              flash_byte(a)};
   endfunction

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
   endfunction

   function automatic int pick_waits();
      int v;
      v = 0;
      repeat (3) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = (v << 1) | int'(lfsr_state[0]);
      end
      return v % 6;
   endfunction

   task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("[FAIL] %0d ns %s expected %h got %h", $time, sig, exp, act);
      error_count++;
   endtask

   task automatic finish_test(input string name);
      test_count++;
      if (error_count == err_start) begin
         pass_count++;
         $display("%0d ns: test %s passed", $time, name);
      end else begin
         $display("%0d ns: test %s FAILED with %0d errors", $time, name,
                  error_count - err_start);
      end
   endtask

   task automatic launch_boot(input logic [23:0] faddr, input logic [15:0] cnt,
                              input logic [31:0] base);
      @(posedge clk);
      cur_flash = faddr;
      cur_count = cnt;
      cur_base = base;
      first_write = total_writes;
      done_start = total_done;
      err_start = error_count;
      start <= 1'b1;
      flash_addr <= faddr;
      word_count <= cnt;
      mem_base <= base;
      @(posedge clk);
      start <= 1'b0;
   endtask

   task automatic await_boot(input string name, input logic need_full);
      int limit;
      int cycles;
      limit = int'(cur_count) * 4 * 40 * sck_div + stall + 2000;
      cycles = 0;
      while (total_done == done_start && cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      if (total_done == done_start) begin
         $display("%0d ns: %s never signalled done", $time, name);
         error_count++;
      end
      repeat (50) @(posedge clk);   // Room for a stray late write
      if (total_writes - first_write != int'(cur_count)) begin
         $display("%0d ns: %s made %0d writes instead of %0d", $time, name,
                  total_writes - first_write, cur_count);
         error_count++;
      end
      if (total_done - done_start > 1) begin
         $display("%0d ns: %s pulsed done %0d times", $time, name, total_done - done_start);
         error_count++;
      end
      if (spi_cs_n !== 1'b1)
         report_mismatch("spi_cs_n", 32'd1, 32'(spi_cs_n));
      if (busy !== 1'b0)
         report_mismatch("busy", 32'd0, 32'(busy));
      if (bad_cmd) begin
         $display("%0d ns: flash model received a wrong opcode", $time);
         error_count++;
      end
      if (need_full && !saw_full) begin
         $display("%0d ns: %s never filled the FIFO", $time, name);
         error_count++;
      end
      finish_test(name);
   endtask

   // Wishbone memory with random wait states
   always @(posedge clk) begin
      if (!arst_n) begin
         wb_ack <= 1'b0;
         pending = 1'b0;
      end else if (wb_ack) begin
         wb_ack <= 1'b0;
      end else if (wb_cyc && wb_stb) begin
         if (!pending) begin
            pending = 1'b1;
            wait_left = max_wait ? 5 : pick_waits();
            if (total_writes == first_write)
               wait_left += stall;            // Long first stall backs up the FIFO
         end
         if (wait_left == 0) begin
            wb_ack <= 1'b1;
            pending = 1'b0;
         end else begin
            wait_left--;
         end
      end
   end

   // Compare every accepted write
   always @(posedge clk) begin
      if (arst_n && wb_cyc && wb_stb && wb_ack) begin
         write_idx = total_writes - first_write;
         if (write_idx >= int'(cur_count)) begin
            $display("%0d ns: extra write to %h past %0d words", $time, wb_adr, cur_count);
            error_count++;
         end else begin
            if (wb_adr !== cur_base + 32'(4 * write_idx))
               report_mismatch("wb_adr", cur_base + 32'(4 * write_idx), wb_adr);
            if (wb_dat_w !== ref_word(cur_flash + 24'(4 * write_idx)))
               report_mismatch("wb_dat_w", ref_word(cur_flash + 24'(4 * write_idx)), wb_dat_w);
            if (wb_sel !== 4'hf)
               report_mismatch("wb_sel", 32'hf, 32'(wb_sel));
            if (wb_we !== 1'b1)
               report_mismatch("wb_we", 32'd1, 32'(wb_we));
         end
         total_writes++;
      end
      if (arst_n && done)
         total_done++;
      if (i_flash_boot_top.full)
         saw_full = 1'b1;
   end

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("Watchdog expired after %0d cycles, the run hung", watchdog_cycles);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      arst_n = 1'b0;
      start = 1'b0;
      flash_addr = '0;
      word_count = '0;
      mem_base = '0;
      repeat (4) @(posedge clk);
      arst_n <= 1'b1;
      repeat (3) @(posedge clk);
      if (spi_cs_n !== 1'b1)
         report_mismatch("spi_cs_n", 32'd1, 32'(spi_cs_n));
      if (spi_sck !== 1'b0)
         report_mismatch("spi_sck", 32'd0, 32'(spi_sck));
      if (wb_cyc !== 1'b0)
         report_mismatch("wb_cyc", 32'd0, 32'(wb_cyc));
      if (wb_stb !== 1'b0)
         report_mismatch("wb_stb", 32'd0, 32'(wb_stb));
      if (busy !== 1'b0)
         report_mismatch("busy", 32'd0, 32'(busy));
      if (done !== 1'b0)
         report_mismatch("done", 32'd0, 32'(done));
      finish_test("after reset");

      launch_boot(24'h000000, 16'd16, 32'h0000_0000);
      await_boot("basic boot", 1'b0);

      launch_boot(24'h012345, 16'd5, 32'h8000_1000);
      await_boot("offset boot", 1'b0);

      stall = stall_cycles;
      max_wait = 1'b1;
      launch_boot(24'h000400, 16'd40, 32'h0001_0000);
      await_boot("back-pressure", 1'b1);
      stall = 0;
      max_wait = 1'b0;

      launch_boot(24'h000100, 16'd1, 32'h0000_2000);
      await_boot("single word", 1'b0);

      // Second start mid-run must be dropped
      launch_boot(24'h000200, 16'd12, 32'h0000_3000);
      repeat (100) @(posedge clk);
      start <= 1'b1;
      flash_addr <= 24'habcdef;
      word_count <= 16'd3;
      mem_base <= 32'h9000_0000;
      @(posedge clk);
      start <= 1'b0;
      await_boot("start while busy", 1'b0);

      $display("%0d tests, %0d passed, %0d errors", test_count, pass_count, error_count);
      if (error_count == 0 && pass_count == test_count) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== wb_boot_writer.sv ====
`default_nettype none

module wb_boot_writer import flash_boot_pkg::*; (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      start,
   input  logic [wb_addr_w-1:0]      mem_base,
   input  logic [count_w-1:0]        word_count,
   input  logic                      empty,
   input  logic [word_w-1:0]         pop_data,
   input  logic                      wb_ack,
   output logic                      pop,
   output logic                      wb_cyc,
   output logic                      wb_stb,
   output logic                      wb_we,
   output logic [wb_addr_w-1:0]      wb_adr,
   output logic [word_w-1:0]         wb_dat_w,
   output logic [bytes_per_word-1:0] wb_sel,
   output logic                      busy,
   output logic                      done
);

   logic [count_w-1:0] words_left;
   logic               accepted;

   assign accepted = wb_stb && wb_ack;
   assign pop = accepted;                      // Head leaves with the ack
   assign wb_we = wb_stb;                      // Write only
   assign wb_sel = {bytes_per_word{wb_stb}};

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy <= 1'b0;
         done <= 1'b0;
         wb_cyc <= 1'b0;
         wb_stb <= 1'b0;
         words_left <= '0;
      end else begin
         done <= 1'b0;
         if (!busy) begin
            if (start) begin
               if (word_count == '0) begin
                  done <= 1'b1;                // Nothing to copy
               end else begin
                  busy <= 1'b1;
                  words_left <= word_count;
               end
            end
         end else if (!wb_cyc) begin
            if (!empty) begin
               wb_cyc <= 1'b1;
               wb_stb <= 1'b1;
            end
         end else if (wb_ack) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            words_left <= words_left - 1'b1;
            if (words_left == count_w'(1)) begin
               busy <= 1'b0;
               done <= 1'b1;
            end
         end
      end
   end

   // Address and data, held for the whole transfer
   always_ff @(posedge clk) begin
      if (!busy && start) begin
         wb_adr <= mem_base;
      end else if (accepted) begin
         wb_adr <= wb_adr + wb_addr_w'(bytes_per_word);
      end
      if (busy && !wb_cyc && !empty) begin
         wb_dat_w <= pop_data;
      end
   end

   a_stb_in_cyc: assert property (@(posedge clk) disable iff (!arst_n)
      wb_stb |-> wb_cyc);

   a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
      (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_dat_w)));

endmodule

`default_nettype wire
